// File: run_sim.sh
#!/bin/sh
# Builds the serial arithmetic testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_serial_arith -Mdir obj_dir -f sim.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_serial_arith)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "NO ERRORS"; then
  echo "Simulation passed"
  exit 0
fi

echo "Simulation failed"
exit 1

// File: sim.f
+incdir+verilog
verilog/order_pkg.sv
verilog/timing_pkg.sv
verilog/word_timer.sv
verilog/order_gates.sv
verilog/multiplicand_tank.sv
verilog/accumulator_tank.sv
verilog/serial_arith_unit.sv
tests/tb_serial_arith.sv

// File: tests/tb_serial_arith.sv
// Random words and orders from a 32-bit Galois LFSR seeded with 20; the run is capped at 200 orders.
`default_nettype none

`include "arith_cfg.svh"

module tb_serial_arith;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int W            = `ARITH_WORD_BITS;
  localparam int ORDER_CYCLES = 2 * `ARITH_STAGE_LEN;     // Stage 1 plus Stage 2.
  localparam int TIMEOUT      = 200 * ORDER_CYCLES + 100;  // Budget of 200 orders.
  localparam int ROUNDS       = 85;                        // One random order plus READ.

  logic              clk;
  logic              rst_n;
  logic              order_valid;
  order_pkg::order_e order;
  logic              mib;
  logic              ready;
  logic              mib_req;
  logic              acc_bit;
  logic              out_valid;
  logic              sign_neg;

  logic [31:0]       lfsr;         // Random state.
  logic [W-1:0]      model_acc;    // Reference accumulator.
  order_pkg::order_e order_q[$];   // Orders still to run.
  logic [W-1:0]      word_q[$];    // Bus word of each order.
  int                errors;
  int                checks;
  int                strays;       // Strobes sent while busy.
  int                orders_run;
  int                cycles;       // Watchdog count.

  serial_arith_unit dut0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .order_valid (order_valid),
    .order       (order),
    .mib         (mib),
    .ready       (ready),
    .mib_req     (mib_req),
    .acc_bit     (acc_bit),
    .out_valid   (out_valid),
    .sign_neg    (sign_neg)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period.
  end

  // One LFSR step per random bit.
  function automatic logic next_bit();
    logic out;
    out  = lfsr[0];
    lfsr = lfsr >> 1;
    if (out) begin
      lfsr = lfsr ^ 32'h8020_0003;  // Taps 32, 22, 2, 1.
    end
    return out;
  endfunction

  function automatic logic [W-1:0] next_word();
    logic [W-1:0] w;
    w = '0;
    repeat (W) begin
      w = {next_bit(), w[W-1:1]};
    end
    return w;
  endfunction

  // Codes 0 to 3, the orders that change the accumulator.
  function automatic order_pkg::order_e random_arith_order();
    logic [1:0] sel;
    sel[0] = next_bit();
    sel[1] = next_bit();
    return order_pkg::order_e'({1'b0, sel});
  endfunction

  // Accumulator after one order, modulo 2^36.
  function automatic logic [W-1:0] model_next(input order_pkg::order_e op,
                                              input logic [W-1:0] acc,
                                              input logic [W-1:0] word);
    case (op)
      order_pkg::ORD_CLEAR_ADD:  return word;
      order_pkg::ORD_ADD:        return acc + word;
      order_pkg::ORD_SUB:        return acc - word;
      order_pkg::ORD_DOUBLE_ADD: return acc + {word[W-2:0], 1'b0};  // Top bit is lost.
      default:                   return acc;                        // TEST and READ.
    endcase
  endfunction

  task automatic check_word(input string name, input logic [W-1:0] got,
                            input logic [W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_ready(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s low for %0d cycles expected %0d",
               $time, name, got, exp);
    end
  endtask

  task automatic note_error(input string msg);
    errors++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  task automatic queue_order(input order_pkg::order_e op, input logic [W-1:0] word);
    order_q.push_back(op);
    word_q.push_back(word);
  endtask

  // Issues one order at a falling edge with ready high and follows it to ready.
  task automatic run_order(input order_pkg::order_e op, input logic [W-1:0] word);
    int           busy;
    int           bit_idx;
    int           rd_idx;
    logic         exp_sign;
    logic [W-1:0] tx_word;
    logic [W-1:0] rd_word;
    busy    = 0;
    bit_idx = 0;
    rd_idx  = 0;
    tx_word = word;
    rd_word = '0;
    if (ready !== 1'b1) begin
      note_error($sformatf("DUT not ready when %s was issued", op.name()));
    end
    order       = op;
    order_valid = 1'b1;
    @(negedge clk);
    order_valid = 1'b0;
    while (ready !== 1'b1 && busy < ORDER_CYCLES + 8) begin
      busy++;
      order       = random_arith_order();   // Must be ignored while busy.
      order_valid = next_bit() & next_bit();
      if (order_valid) begin
        strays++;
      end
      exp_sign = 1'b0;
      if (mib_req === 1'b1) begin
        mib      = tx_word[0];              // Bit k in digit k.
        exp_sign = (op == order_pkg::ORD_TEST) && (bit_idx == W - 1) && word[W-1];
        tx_word  = tx_word >> 1;
        bit_idx++;
      end else begin
        mib = next_bit();                   // Junk outside the request.
      end
      #2;                                   // Let sign_neg follow mib.
      check_bit("sign_neg", sign_neg, exp_sign);
      if (out_valid === 1'b1) begin
        rd_word = {acc_bit, rd_word[W-1:1]};
        rd_idx++;
      end
      @(negedge clk);
      order_valid = 1'b0;
    end
    check_ready("ready", busy, ORDER_CYCLES);
    if (bit_idx != ((op == order_pkg::ORD_READ) ? 0 : W)) begin
      note_error($sformatf("mib_req was high for %0d cycles in %s", bit_idx, op.name()));
    end
    if (rd_idx != ((op == order_pkg::ORD_READ) ? W : 0)) begin
      note_error($sformatf("out_valid was high for %0d cycles in %s", rd_idx, op.name()));
    end
    if (op == order_pkg::ORD_READ) begin
      check_word("acc_bit", rd_word, model_acc);
    end
    model_acc = model_next(op, model_acc, word);
    orders_run++;
  endtask

  initial begin
    order_pkg::order_e op;
    logic [W-1:0]      word;
    logic [2:0]        sel;
    lfsr        = 32'd20;
    model_acc   = '0;
    errors      = 0;
    checks      = 0;
    strays      = 0;
    orders_run  = 0;
    rst_n       = 1'b0;
    order_valid = 1'b0;
    order       = order_pkg::ORD_READ;
    mib         = 1'b0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_bit("ready", ready, 1'b1);
    check_bit("mib_req", mib_req, 1'b0);
    check_bit("out_valid", out_valid, 1'b0);
    check_bit("sign_neg", sign_neg, 1'b0);

    queue_order(order_pkg::ORD_READ, '0);  // Accumulator is zero after reset.
    repeat (4) begin
      queue_order(order_pkg::ORD_CLEAR_ADD, next_word());
      queue_order(order_pkg::ORD_READ, '0);
    end
    word = next_word();
    queue_order(order_pkg::ORD_TEST, {1'b1, word[W-2:0]});  // Negative word.
    queue_order(order_pkg::ORD_TEST, {1'b0, word[W-2:0]});  // Positive word.
    queue_order(order_pkg::ORD_READ, '0);
    repeat (ROUNDS) begin
      sel[0] = next_bit();
      sel[1] = next_bit();
      sel[2] = next_bit();
      case (sel)
        3'd0:       op = order_pkg::ORD_CLEAR_ADD;
        3'd1, 3'd2: op = order_pkg::ORD_ADD;
        3'd3, 3'd4: op = order_pkg::ORD_SUB;
        3'd5, 3'd6: op = order_pkg::ORD_DOUBLE_ADD;
        default:    op = order_pkg::ORD_TEST;
      endcase
      queue_order(op, next_word());
      queue_order(order_pkg::ORD_READ, '0);
    end

    while (order_q.size() > 0) begin
      op   = order_q.pop_front();
      word = word_q.pop_front();
      run_order(op, word);
    end

    $display("Orders run: %0d, stray strobes: %0d, checks: %0d, errors: %0d",
             orders_run, strays, checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // Watchdog on the whole run.
  initial begin
    cycles = 0;
    while (cycles < TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the test did not end within %0d cycles", TIMEOUT);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule : tb_serial_arith

`default_nettype wire

// File: verilog/accumulator_tank.sv
// The store only moves in Stage 2, so one Stage 2 is one full turn and the word stays aligned to digit 0.
`default_nettype none

`include "arith_cfg.svh"

module accumulator_tank (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          mcand,      // Serial operand, LSB first.
  input  wire                          stage2,     // Stage 2 of main control.
  input  wire                          acc_clear,  // Take operand alone.
  input  wire                          acc_sub,    // Subtract operand.
  input  wire                          acc_read,   // Recirculate for read-out.
  input  wire [`ARITH_DIGIT_W-1:0]     digit,      // Digit time.
  output logic                         acc_bit     // Bit leaving the tank.
);

  logic [`ARITH_WORD_BITS-1:0] acc_q;    // Delay line, bit 0 leaves first.
  logic                        carry_q;  // Carry between digits.
  logic                        op_bit;   // Operand after inversion.
  logic                        cin;      // Carry into this digit.
  logic                        sum_bit;
  logic                        cout;
  logic                        new_bit;  // Bit written at the top.

  // Two's complement subtract.
  // Invert the operand and add one at digit 0.
  assign op_bit = mcand ^ acc_sub;
  assign cin    = (digit == '0) ? acc_sub : carry_q;  // Carry preset at the word start.

  assign sum_bit = acc_q[0] ^ op_bit ^ cin;
  assign cout    = (acc_q[0] & op_bit) | (cin & (acc_q[0] ^ op_bit));

  always_comb begin
    if (acc_read) begin
      new_bit = acc_q[0];      // Unchanged.
    end else if (acc_clear) begin
      new_bit = mcand;         // Old content dropped.
    end else begin
      new_bit = sum_bit;       // ADD, SUB, DOUBLE_ADD, TEST.
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q   <= '0;
      carry_q <= 1'b0;
    end else if (stage2) begin
      acc_q   <= {new_bit, acc_q[`ARITH_WORD_BITS-1:1]};
      carry_q <= cout;
    end
  end

  assign acc_bit = acc_q[0];  // LSB first during READ.

  // Gates for one order only.
  a_clear_sub : assert property (@(posedge clk) disable iff (!rst_n)
    !(acc_clear && acc_sub))
    else $error("Clear and subtract gates high together.");

endmodule : accumulator_tank

`default_nettype wire

// File: verilog/arith_cfg.svh
// Word and stage sizes shared by every tank and timer; the digit counter must hold STAGE_LEN - 1.
`ifndef ARITH_CFG_SVH
`define ARITH_CFG_SVH

// Bits in one machine word, sent LSB first.
`define ARITH_WORD_BITS 36

// Digit times in one stage.
// A stage is one full trip around a tank.
`define ARITH_STAGE_LEN `ARITH_WORD_BITS

// Width of the digit counter.
`define ARITH_DIGIT_W 6

// Index of the last digit in a stage, sized for the digit counter.
`define ARITH_LAST_DIGIT `ARITH_DIGIT_W'(`ARITH_STAGE_LEN - 1)

`endif

// File: verilog/multiplicand_tank.sv
// Store content outside Stage 2 is not meaningful; mcand is zero unless mcand_out or shift_out is set.
`default_nettype none

`include "arith_cfg.svh"

module multiplicand_tank (
  input  wire  clk,
  input  wire  rst_n,
  input  wire  mib,         // Main input bus bit.
  input  wire  mem_read,    // Order reads the bus.
  input  wire  stage1,      // Stage 1 of main control.
  input  wire  stage2,      // Stage 2 of main control.
  input  wire  clear_n,     // Low drops the recirculating word.
  input  wire  pre_shift,   // Store input via the one-digit delay.
  input  wire  mcand_out,   // Straight stream to the adder.
  input  wire  shift_out,   // Delayed stream to the adder.
  input  wire  sign_pulse,  // Sign digit strobe.
  output logic mcand,       // Serial operand.
  output logic sign_neg     // Word is negative.
);

  logic [`ARITH_WORD_BITS-1:0] store_q;  // Delay line, bit 0 leaves first.
  logic                        pp_q;     // One-digit pre-shift delay.
  logic                        mcand_in;
  logic                        mcand_ppi;
  logic                        mcand_ppo;

  assign mcand_in  = mib & stage2 & mem_read;                     // Bus word admitted.
  assign mcand_ppi = (store_q[0] & ~stage1 & clear_n) | mcand_in;  // Old word or bus.
  assign mcand_ppo = pre_shift ? pp_q : mcand_ppi;                 // Left-shift option.

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      store_q <= '0;
      pp_q    <= 1'b0;
    end else begin
      if (stage1 | stage2) begin
        store_q <= {mcand_ppo, store_q[`ARITH_WORD_BITS-1:1]};  // Shift toward bit 0.
      end
      pp_q <= stage2 ? mcand_ppi : 1'b0;  // Zero at digit 0 of each word
    end
  end

  // Delayed stream doubles the word, top bit falls off.
  assign mcand    = (mcand_ppi & mcand_out) | (pp_q & shift_out);
  assign sign_neg = mcand_ppi & sign_pulse;

  // Pre-shift is only meaningful on a bus word.
  a_pre_shift_bus : assert property (@(posedge clk) disable iff (!rst_n)
    pre_shift |-> mem_read)
    else $error("Pre-shift without a bus order.");

endmodule : multiplicand_tank

`default_nettype wire

// File: verilog/order_gates.sv
// Gates are registered from the predicted next digit, so they lag one digit only at the start of Stage 1.
`default_nettype none

`include "arith_cfg.svh"

module order_gates (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire timing_pkg::stage_e      stage,       // Stage from the timer.
  input  wire [`ARITH_DIGIT_W-1:0]     digit,       // Digit time from the timer.
  input  wire                          last_digit,  // Stage ends this cycle.
  input  wire order_pkg::order_e       cur_order,   // Order being run.
  output logic                         mem_read,    // Order takes a word from the bus.
  output logic                         stage1,      // Stage 1 gate.
  output logic                         stage2,      // Stage 2 gate.
  output logic                         clear_n,     // Low drops the old multiplicand.
  output logic                         pre_shift,   // Route store input through the delay.
  output logic                         mcand_out,   // Straight operand to the adder.
  output logic                         shift_out,   // Shifted operand to the adder.
  output logic                         sign_pulse,  // Sign digit strobe for TEST.
  output logic                         acc_clear,   // Accumulator takes operand alone.
  output logic                         acc_sub,     // Accumulator subtracts.
  output logic                         acc_read,    // Accumulator read-out.
  output logic                         mib_req,     // Bus word wanted now.
  output logic                         out_valid    // acc_bit is valid.
);

  timing_pkg::stage_e           nxt_stage;  // Stage in the next cycle.
  logic [`ARITH_DIGIT_W-1:0]    nxt_digit;  // Digit in the next cycle.
  logic                         busy_n;     // Order still running next cycle.
  logic                         two_n;      // Stage 2 next cycle.
  logic                         bus_n;      // Bus order next cycle.

  // Step the timer ahead by one digit.
  always_comb begin
    nxt_stage = stage;
    nxt_digit = digit + 1'b1;
    if (last_digit) begin
      nxt_digit = '0;
      nxt_stage = (stage == timing_pkg::STG_ONE) ? timing_pkg::STG_TWO
                                                 : timing_pkg::STG_IDLE;
    end
  end

  assign busy_n = (nxt_stage != timing_pkg::STG_IDLE);
  assign two_n  = (nxt_stage == timing_pkg::STG_TWO);
  assign bus_n  = busy_n && (cur_order != order_pkg::ORD_READ);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_read   <= 1'b0;
      stage1     <= 1'b0;
      stage2     <= 1'b0;
      clear_n    <= 1'b1;
      pre_shift  <= 1'b0;
      mcand_out  <= 1'b0;
      shift_out  <= 1'b0;
      sign_pulse <= 1'b0;
      acc_clear  <= 1'b0;
      acc_sub    <= 1'b0;
      acc_read   <= 1'b0;
      mib_req    <= 1'b0;
      out_valid  <= 1'b0;
    end else begin
      mem_read   <= bus_n;                                          // All but READ.
      stage1     <= (nxt_stage == timing_pkg::STG_ONE);
      stage2     <= two_n;
      clear_n    <= ~(two_n & bus_n);                               // Bus word replaces store.
      pre_shift  <= two_n && (cur_order == order_pkg::ORD_DOUBLE_ADD);
      shift_out  <= two_n && (cur_order == order_pkg::ORD_DOUBLE_ADD);
      mcand_out  <= two_n && (cur_order == order_pkg::ORD_CLEAR_ADD ||
                              cur_order == order_pkg::ORD_ADD ||
                              cur_order == order_pkg::ORD_SUB);
      sign_pulse <= two_n && (cur_order == order_pkg::ORD_TEST) &&
                    (nxt_digit == `ARITH_LAST_DIGIT);              // Sign sits in the top digit.
      acc_clear  <= busy_n && (cur_order == order_pkg::ORD_CLEAR_ADD);
      acc_sub    <= busy_n && (cur_order == order_pkg::ORD_SUB);
      acc_read   <= busy_n && (cur_order == order_pkg::ORD_READ);
      mib_req    <= two_n & bus_n;
      out_valid  <= two_n && (cur_order == order_pkg::ORD_READ);
    end
  end

  // Each stage gate matches the timer stage, so the two never overlap.
  a_stage_excl : assert property (@(posedge clk) disable iff (!rst_n)
    (!stage1 || (stage == timing_pkg::STG_ONE)) &&
    (!stage2 || (stage == timing_pkg::STG_TWO)))
    else $error("Stage gate disagrees with the timer stage.");

endmodule : order_gates

`default_nettype wire

// File: verilog/order_pkg.sv
// Order codes of the arithmetic path; only the six orders without fetch, multiply or shift exist.
`default_nettype none

package order_pkg;

  // Orders accepted by the word timer.
  // Every code but ORD_READ takes its operand from the main input bus.
  typedef enum logic [2:0] {
    ORD_CLEAR_ADD  = 3'd0,  // Accumulator takes the word.
    ORD_ADD        = 3'd1,  // Accumulator plus word.
    ORD_SUB        = 3'd2,  // Accumulator minus word.
    ORD_DOUBLE_ADD = 3'd3,  // Accumulator plus twice the word.
    ORD_TEST       = 3'd4,  // Sign test of the word.
    ORD_READ       = 3'd5   // Stream the accumulator out.
  } order_e;

endpackage : order_pkg

`default_nettype wire

// File: verilog/serial_arith_unit.sv
// No handshake; mib must be valid in every cycle of mib_req and acc_bit is only meaningful with out_valid.
`default_nettype none

`include "arith_cfg.svh"

module serial_arith_unit (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     order_valid,  // Order strobe.
  input  wire order_pkg::order_e  order,        // Order code.
  input  wire                     mib,          // Main input bus bit.
  output logic                    ready,        // Can accept an order.
  output logic                    mib_req,      // Bus bit wanted.
  output logic                    acc_bit,      // Accumulator bit, LSB first.
  output logic                    out_valid,    // READ data valid.
  output logic                    sign_neg      // TEST found a negative word.
);

  wire timing_pkg::stage_e           stage;
  wire [`ARITH_DIGIT_W-1:0]          digit;
  wire                               last_digit;
  wire order_pkg::order_e            cur_order;
  wire                               mem_read;
  wire                               stage1;
  wire                               stage2;
  wire                               clear_n;
  wire                               pre_shift;
  wire                               mcand_out;
  wire                               shift_out;
  wire                               sign_pulse;
  wire                               acc_clear;
  wire                               acc_sub;
  wire                               acc_read;
  wire                               mcand;       // Operand stream into the adder.

  word_timer timer0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .order_valid (order_valid),
    .order       (order),
    .stage       (stage),
    .digit       (digit),
    .last_digit  (last_digit),
    .cur_order   (cur_order),
    .ready       (ready)
  );

  order_gates gates0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .stage      (stage),
    .digit      (digit),
    .last_digit (last_digit),
    .cur_order  (cur_order),
    .mem_read   (mem_read),
    .stage1     (stage1),
    .stage2     (stage2),
    .clear_n    (clear_n),
    .pre_shift  (pre_shift),
    .mcand_out  (mcand_out),
    .shift_out  (shift_out),
    .sign_pulse (sign_pulse),
    .acc_clear  (acc_clear),
    .acc_sub    (acc_sub),
    .acc_read   (acc_read),
    .mib_req    (mib_req),
    .out_valid  (out_valid)
  );

  multiplicand_tank mcand0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .mib        (mib),
    .mem_read   (mem_read),
    .stage1     (stage1),
    .stage2     (stage2),
    .clear_n    (clear_n),
    .pre_shift  (pre_shift),
    .mcand_out  (mcand_out),
    .shift_out  (shift_out),
    .sign_pulse (sign_pulse),
    .mcand      (mcand),
    .sign_neg   (sign_neg)
  );

  accumulator_tank acc0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .mcand     (mcand),
    .stage2    (stage2),
    .acc_clear (acc_clear),
    .acc_sub   (acc_sub),
    .acc_read  (acc_read),
    .digit     (digit),
    .acc_bit   (acc_bit)
  );

endmodule : serial_arith_unit

`default_nettype wire

// File: verilog/timing_pkg.sv
// Main control stages; there is no single-step stage, so IDLE is the only state outside an order.
`default_nettype none

package timing_pkg;

  // Stage of the main control.
  // Each order runs Stage 1 then Stage 2, one word time each.
  typedef enum logic [1:0] {
    STG_IDLE = 2'd0,  // Waiting for an order.
    STG_ONE  = 2'd1,  // Stage 1, tanks prepare.
    STG_TWO  = 2'd2   // Stage 2, word passes through.
  } stage_e;

endpackage : timing_pkg

`default_nettype wire

// File: verilog/word_timer.sv
// Orders are taken only in IDLE; an order_valid seen while busy is dropped without any flag.
`default_nettype none

`include "arith_cfg.svh"

module word_timer (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          order_valid,  // One-cycle order strobe.
  input  wire order_pkg::order_e       order,        // Sampled with order_valid.
  output timing_pkg::stage_e           stage,        // Current stage.
  output logic [`ARITH_DIGIT_W-1:0]    digit,        // Digit time within the stage.
  output logic                         last_digit,   // Final digit of a stage.
  output order_pkg::order_e            cur_order,    // Order being executed.
  output logic                         ready         // Idle and able to accept.
);

  timing_pkg::stage_e           stage_q;      // Stage register.
  logic [`ARITH_DIGIT_W-1:0]    digit_q;      // Digit counter.
  order_pkg::order_e            cur_order_q;  // Latched order.
  logic                         accept;       // Order taken this edge.

  assign ready      = (stage_q == timing_pkg::STG_IDLE);
  assign accept     = order_valid & ready;
  assign last_digit = (stage_q != timing_pkg::STG_IDLE) && (digit_q == `ARITH_LAST_DIGIT);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stage_q <= timing_pkg::STG_IDLE;
      digit_q <= '0;
    end else if (accept) begin
      stage_q <= timing_pkg::STG_ONE;                   // Stage 1 starts at digit 0.
      digit_q <= '0;
    end else if (last_digit) begin
      digit_q <= '0;
      stage_q <= (stage_q == timing_pkg::STG_ONE) ? timing_pkg::STG_TWO
                                                  : timing_pkg::STG_IDLE;
    end else if (stage_q != timing_pkg::STG_IDLE) begin
      digit_q <= digit_q + 1'b1;                        // Next digit time.
    end
  end

  // Order register only loads on acceptance.
  always_ff @(posedge clk) begin
    if (accept) begin
      cur_order_q <= order;
    end
  end

  assign stage     = stage_q;
  assign digit     = digit_q;
  assign cur_order = cur_order_q;

  // A stage is exactly one word long.
  a_digit_range : assert property (@(posedge clk) disable iff (!rst_n)
    digit_q <= `ARITH_LAST_DIGIT)
    else $error("Digit counter passed the last digit.");

endmodule : word_timer

`default_nettype wire
